//--- Bender.yml
package:
  name: load_tile

sources:
  - design/load_pkg.sv
  - design/word_chan_if.sv
  - design/burst_issuer.sv
  - design/beat_unpacker.sv
  - design/word_fifo.sv
  - design/load_drain.sv
  - design/load_tile_top.sv
  - target: test
    files:
      - verif/tb_clkgen.sv
      - verif/rmst_model.sv
      - verif/load_props.sv
      - verif/tb_top.sv

//--- design/beat_unpacker.sv
/*
 * Beat unpacker
 * Pops one beat from the read master, then pushes its words low word
 * first, one per cycle. Padding past the load length is dropped and the
 * final word of the load is flagged with push_last.
 */
`timescale 1ns/10ps
`default_nettype none

module beat_unpacker import load_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  len_t  len,

    input  logic  rmst_user_data_available,
    input  beat_t rmst_user_buffer_data,
    output logic  rmst_user_read_buffer,

    output logic  push,
    output word_t push_data,
    output logic  push_last
);

    beat_t          beat_q;
    logic           have;
    logic [WIW-1:0] widx;
    len_t           wcnt;
    // set after the last word until the next beat arrives
    logic           tail;

    // index is back at 0 whenever no beat is held
    assign rmst_user_read_buffer = rmst_user_data_available && !have;

    assign push      = have && !tail;
    assign push_data = beat_q[DW-1:0];
    assign push_last = push && (wcnt == len - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            have <= 1'b0;
            widx <= '0;
            wcnt <= '0;
            tail <= 1'b0;
        end else begin
            if (rmst_user_read_buffer) begin
                have <= 1'b1;
                widx <= '0;
                tail <= 1'b0;
            end else if (have) begin
                widx <= widx + 1'b1;
                if (widx == WIW'(WCNT - 1)) begin
                    have <= 1'b0;
                end
            end

            if (push_last) begin
                wcnt <= '0;
                tail <= 1'b1;
            end else if (push) begin
                wcnt <= wcnt + 1'b1;
            end
        end
    end

    // low word leaves first
    always_ff @(posedge clk) begin
        if (rmst_user_read_buffer) begin
            beat_q <= rmst_user_buffer_data;
        end else if (have) begin
            beat_q <= beat_q >> DW;
        end
    end

endmodule

`default_nettype wire

//--- design/burst_issuer.sv
/*
 * Burst issuer
 * Latches a load command and splits it into read-master bursts of at
 * most BLEN words. A burst is issued only when the word FIFO credits
 * cover the whole burst; popped words return credits one at a time.
 */
`timescale 1ns/10ps
`default_nettype none

module burst_issuer import load_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  load_start,
    input  addr_t load_base,
    input  len_t  load_len,
    output logic  load_busy,
    output len_t  len,

    input  logic  pop,

    output logic  rmst_go,
    output addr_t rmst_read_base,
    output len_t  rmst_read_length,
    input  logic  rmst_done,

    input  logic  load_done
);

    len_t          remain;
    addr_t         next_base;
    len_t          burst_words;
    logic [CW-1:0] credits;
    logic [CW-1:0] spend;
    logic [CW-1:0] gain;
    logic          pending;
    logic          accept;

    // zero-length commands are ignored
    assign accept = load_start && !load_busy && (load_len != '0);

    assign burst_words = (remain > len_t'(BLEN)) ? len_t'(BLEN) : remain;

    // go once the master is idle and the previous request has been taken
    assign rmst_go = load_busy && rmst_done && !pending && (remain != '0)
                     && (len_t'(credits) >= burst_words);

    assign rmst_read_base   = next_base;
    assign rmst_read_length = burst_words << 2;

    assign spend = rmst_go ? burst_words[CW-1:0] : '0;
    assign gain  = {{(CW-1){1'b0}}, pop};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_busy <= 1'b0;
            len       <= '0;
            remain    <= '0;
            pending   <= 1'b0;
            credits   <= CW'(FIFO_DEPTH);
        end else begin
            if (accept) begin
                load_busy <= 1'b1;
                len       <= load_len;
                remain    <= load_len;
            end else if (rmst_go) begin
                remain <= remain - burst_words;
            end

            if (load_done) begin
                load_busy <= 1'b0;
            end

            // request is taken once the master drops done
            if (rmst_go) begin
                pending <= 1'b1;
            end else if (!rmst_done) begin
                pending <= 1'b0;
            end

            credits <= credits - spend + gain;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            next_base <= load_base;
        end else if (rmst_go) begin
            next_base <= next_base + addr_t'(rmst_read_length);
        end
    end

endmodule

`default_nettype wire

//--- design/load_drain.sv
/*
 * Load drain
 * Two-entry staging queue in front of the external sink. The head word
 * goes out while a sink credit is held, freeing a channel credit.
 */
`timescale 1ns/10ps
`default_nettype none

module load_drain import load_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    word_chan_if.rx chan,

    output logic  out_valid,
    output word_t out_data,
    output logic  out_last,
    input  logic  out_credit,

    output logic  load_done
);

    wentry_t             q [DRAIN_DEPTH];
    logic [DRAIN_AW-1:0] head;
    logic [DRAIN_AW-1:0] tail;
    logic [DRAIN_AW:0]   count;
    logic [CW-1:0]       scred;
    logic                send;

    assign send = (count != '0) && (scred != '0);

    assign out_valid   = send;
    assign out_data    = q[head].data;
    assign out_last    = q[head].last;
    assign load_done   = send && q[head].last;
    assign chan.credit = send;

    always_ff @(posedge clk) begin
        if (chan.valid) begin
            q[tail] <= '{last: chan.last, data: chan.data};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            scred <= CW'(SINK_CREDITS);
        end else begin
            if (chan.valid) begin
                tail <= tail + 1'b1;
            end
            if (send) begin
                head <= head + 1'b1;
            end

            if (chan.valid && !send) begin
                count <= count + 1'b1;
            end else if (!chan.valid && send) begin
                count <= count - 1'b1;
            end

            if (send && !out_credit) begin
                scred <= scred - 1'b1;
            end else if (!send && out_credit) begin
                scred <= scred + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/load_pkg.sv
/*
 * Load tile package
 * Widths, depths, credit counts and the shared word types used by the
 * burst issuer, beat unpacker, word FIFO and load drain.
 */
`default_nettype none

package load_pkg;

    // data path widths
    localparam int DW   = 32;
    localparam int XDW  = 128;
    localparam int WCNT = XDW / DW;
    localparam int WIW  = $clog2(WCNT);

    // address and length widths, lengths counted in words
    localparam int XAW = 32;
    localparam int LW  = 12;

    // words per read-master burst
    localparam int BLEN = 8;

    // buffering and credits
    localparam int FIFO_DEPTH   = 32;
    localparam int FIFO_AW      = $clog2(FIFO_DEPTH);
    localparam int DRAIN_DEPTH  = 2;
    localparam int DRAIN_AW     = $clog2(DRAIN_DEPTH);
    localparam int CW           = 6;
    localparam int SINK_CREDITS = 4;

    typedef logic [DW-1:0]  word_t;
    typedef logic [XDW-1:0] beat_t;
    typedef logic [XAW-1:0] addr_t;
    typedef logic [LW-1:0]  len_t;

    // one buffered word with its end-of-load marker
    typedef struct packed {
        logic  last;
        word_t data;
    } wentry_t;

endpackage

`default_nettype wire

//--- design/load_tile_top.sv
/*
 * Load tile top level
 * Issuer, unpacker, word FIFO and drain between a 128-bit read master
 * and a credit-based 32-bit word sink.
 */
`timescale 1ns/10ps
`default_nettype none

module load_tile_top import load_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    // load command
    input  logic  load_start,
    input  addr_t load_base,
    input  len_t  load_len,
    output logic  load_busy,
    output logic  load_done,

    // read master
    output logic  rmst_go,
    output addr_t rmst_read_base,
    output len_t  rmst_read_length,
    input  logic  rmst_done,
    input  logic  rmst_user_data_available,
    input  beat_t rmst_user_buffer_data,
    output logic  rmst_user_read_buffer,

    // word sink
    output logic  out_valid,
    output word_t out_data,
    output logic  out_last,
    input  logic  out_credit
);

    len_t  len;
    logic  push;
    word_t push_data;
    logic  push_last;
    logic  pop;

    word_chan_if chan_i ();

    burst_issuer issuer_i (
        .clk              (clk),
        .rst              (rst),
        .load_start       (load_start),
        .load_base        (load_base),
        .load_len         (load_len),
        .load_busy        (load_busy),
        .len              (len),
        .pop              (pop),
        .rmst_go          (rmst_go),
        .rmst_read_base   (rmst_read_base),
        .rmst_read_length (rmst_read_length),
        .rmst_done        (rmst_done),
        .load_done        (load_done)
    );

    beat_unpacker unpacker_i (
        .clk                      (clk),
        .rst                      (rst),
        .len                      (len),
        .rmst_user_data_available (rmst_user_data_available),
        .rmst_user_buffer_data    (rmst_user_buffer_data),
        .rmst_user_read_buffer    (rmst_user_read_buffer),
        .push                     (push),
        .push_data                (push_data),
        .push_last                (push_last)
    );

    word_fifo fifo_i (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .push_last (push_last),
        .pop       (pop),
        .chan      (chan_i.tx)
    );

    load_drain drain_i (
        .clk        (clk),
        .rst        (rst),
        .chan       (chan_i.rx),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_credit (out_credit),
        .load_done  (load_done)
    );

endmodule

`default_nettype wire

//--- design/word_chan_if.sv
/*
 * Word channel between the word FIFO and the load drain
 * Valid/data/last go forward, one credit per freed drain slot comes back.
 */
`timescale 1ns/10ps
`default_nettype none

interface word_chan_if import load_pkg::*; ();

    logic  valid;
    word_t data;
    logic  last;
    // one pulse per drain queue entry released
    logic  credit;

    modport tx (
        output valid, data, last,
        input  credit
    );

    modport rx (
        input  valid, data, last,
        output credit
    );

endinterface

`default_nettype wire

//--- design/word_fifo.sv
/*
 * Word FIFO
 * Circular buffer of FIFO_DEPTH words with their last flags. Words go
 * to the drain only against drain credits; each word sent pulses pop.
 */
`timescale 1ns/10ps
`default_nettype none

module word_fifo import load_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    input  logic  push,
    input  word_t push_data,
    input  logic  push_last,

    output logic  pop,

    word_chan_if.tx chan
);

    wentry_t            mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wptr;
    logic [FIFO_AW-1:0] rptr;
    logic [FIFO_AW:0]   count;
    logic [CW-1:0]      dcred;
    logic               send;

    assign send = (count != '0) && (dcred != '0);

    assign chan.valid = send;
    assign chan.data  = mem[rptr].data;
    assign chan.last  = mem[rptr].last;
    assign pop        = send;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wptr] <= '{last: push_last, data: push_data};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
            dcred <= CW'(DRAIN_DEPTH);
        end else begin
            if (push) begin
                wptr <= wptr + 1'b1;
            end
            if (send) begin
                rptr <= rptr + 1'b1;
            end

            if (push && !send) begin
                count <= count + 1'b1;
            end else if (!push && send) begin
                count <= count - 1'b1;
            end

            // drain slots: spent on send, returned by the drain
            if (send && !chan.credit) begin
                dcred <= dcred - 1'b1;
            end else if (!send && chan.credit) begin
                dcred <= dcred + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- sources.f
design/load_pkg.sv
design/word_chan_if.sv
design/burst_issuer.sv
design/beat_unpacker.sv
design/word_fifo.sv
design/load_drain.sv
design/load_tile_top.sv
verif/tb_clkgen.sv
verif/rmst_model.sv
verif/load_props.sv
verif/tb_top.sv

//--- verif/load_props.sv
/*
 * Burst issuer properties
 * Credit bound and the conditions under which a burst may be issued.
 */
`timescale 1ns/10ps
`default_nettype none

module load_props import load_pkg::*; (
    input logic          clk,
    input logic          rst,
    input logic [CW-1:0] credits,
    input logic          pop,
    input logic          rmst_go,
    input logic          rmst_done,
    input len_t          rmst_read_length
);

    // failure count, read by the testbench at the end of the run
    int unsigned fails = 0;

    // words granted to bursts and not yet popped from the word FIFO
    int inflight;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inflight <= 0;
        end else if (rmst_go) begin
            inflight <= inflight + int'(rmst_read_length) / 4 - int'(pop);
        end else begin
            inflight <= inflight - int'(pop);
        end
    end

    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits <= CW'(FIFO_DEPTH))
        else begin
            $error("issuer credits 0x%h above FIFO depth", credits);
            fails++;
        end

    // the master drops done right after a request, so go must not repeat
    go_single_pulse: assert property (@(posedge clk) disable iff (rst)
        rmst_go |=> !rmst_go)
        else begin
            $error("rmst_go held past the request cycle");
            fails++;
        end

    go_with_credit: assert property (@(posedge clk) disable iff (rst)
        rmst_go |-> (inflight + int'(rmst_read_length) / 4 <= FIFO_DEPTH))
        else begin
            $error("burst of 0x%h bytes issued with 0x%h words in flight",
                   rmst_read_length, inflight);
            fails++;
        end

endmodule

bind burst_issuer load_props props_i (
    .clk              (clk),
    .rst              (rst),
    .credits          (credits),
    .pop              (pop),
    .rmst_go          (rmst_go),
    .rmst_done        (rmst_done),
    .rmst_read_length (rmst_read_length)
);

`default_nettype wire

//--- verif/rmst_model.sv
/*
 * Read master model
 * Takes a burst request, returns 128-bit beats from a computed memory
 * image with a random 0 to 3 cycle gap before each beat.
 */
`timescale 1ns/10ps
`default_nettype none

module rmst_model import load_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  rmst_go,
    input  addr_t rmst_read_base,
    input  len_t  rmst_read_length,
    output logic  rmst_done,
    output logic  rmst_user_data_available,
    output beat_t rmst_user_buffer_data,
    input  logic  rmst_user_read_buffer
);

    localparam word_t MEM_KEY = 32'h5a5a0000;

    logic        go_q;
    addr_t       base_q;
    len_t        bytes_q;
    logic        pop_q;
    addr_t       cur_addr;
    int          beats_left;
    int          wait_cyc;
    logic [31:0] lfsr;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // word at byte address a
    function automatic word_t mem_word(input addr_t a);
        return a ^ MEM_KEY;
    endfunction

    function automatic beat_t make_beat(input addr_t a);
        beat_t b;
        for (int i = 0; i < WCNT; i++) begin
            b[i*DW +: DW] = mem_word(a + addr_t'(4 * i));
        end
        return b;
    endfunction

    // two LFSR bits give the gap before the next beat
    task draw_delay;
        begin
            wait_cyc = int'(lfsr[0]);
            lfsr     = lfsr_next(lfsr);
            wait_cyc = wait_cyc + 2 * int'(lfsr[0]);
            lfsr     = lfsr_next(lfsr);
        end
    endtask

    initial begin
        rmst_done                = 1'b1;
        rmst_user_data_available = 1'b0;
        rmst_user_buffer_data    = '0;
        lfsr                     = 32'hc6acd34b;
        cur_addr                 = '0;
        beats_left               = 0;
        wait_cyc                 = 0;
    end

    always @(posedge clk) begin
        go_q    <= rmst_go;
        base_q  <= rmst_read_base;
        bytes_q <= rmst_read_length;
        pop_q   <= rmst_user_read_buffer;
    end

    always @(negedge clk) begin
        if (rst) begin
            rmst_done                = 1'b1;
            rmst_user_data_available = 1'b0;
            beats_left               = 0;
        end else if (go_q) begin
            rmst_done  = 1'b0;
            cur_addr   = base_q;
            beats_left = (int'(bytes_q) + 15) / 16;
            draw_delay();
        end else if (pop_q) begin
            rmst_user_data_available = 1'b0;
            cur_addr   = cur_addr + 16;
            beats_left = beats_left - 1;
            draw_delay();
            if (beats_left == 0) begin
                rmst_done = 1'b1;
            end
        end else if (!rmst_user_data_available && beats_left != 0) begin
            if (wait_cyc == 0) begin
                rmst_user_buffer_data    = make_beat(cur_addr);
                rmst_user_data_available = 1'b1;
            end else begin
                wait_cyc = wait_cyc - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
/*
 * Testbench clock and reset
 * Free-running clock with reset held high for the first cycles.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // first edge at PERIOD/2, so release lands on a falling edge
    initial begin
        rst = 1'b1;
        #(PERIOD * RST_CYCLES);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/tb_top.sv
/*
 * Load tile testbench
 * Applies a table of loads, models the credit-based word sink and checks
 * data, lengths, bursts, sink credits and completion.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_top import load_pkg::*; ();

    localparam int    NROWS   = 7;
    localparam word_t MEM_KEY = 32'h5a5a0000;

    // base, length in words, gated credit return
    typedef struct packed {
        addr_t base;
        len_t  len;
        logic  gated;
    } load_row_t;

    localparam load_row_t LOADS [NROWS] = '{
        '{32'h0000_1000, 12'd1,  1'b0},
        '{32'h0000_2010, 12'd7,  1'b0},
        '{32'h0000_3000, 12'd8,  1'b1},
        '{32'h0001_0040, 12'd9,  1'b0},
        '{32'h0002_0000, 12'd37, 1'b1},
        '{32'h0003_0100, 12'd37, 1'b0},
        '{32'h0000_5ff0, 12'd9,  1'b1}
    };

    logic  clk, rst;
    logic  load_start, load_busy, load_done;
    addr_t load_base;
    len_t  load_len;
    logic  rmst_go, rmst_done, rmst_user_data_available, rmst_user_read_buffer;
    addr_t rmst_read_base;
    len_t  rmst_read_length;
    beat_t rmst_user_buffer_data;
    logic  out_valid, out_last, out_credit;
    word_t out_data;

    int          err_cnt, passed, failed, cur_row, row_len, word_idx, done_cnt;
    int          burst_bytes, owed, valid_cnt, credit_cnt, cycles, limit;
    addr_t       row_base, next_burst;
    logic        row_active, sink_gated;
    logic [31:0] lfsr;

    tb_clkgen #(.PERIOD(20), .RST_CYCLES(3)) clkgen_i (.clk(clk), .rst(rst));

    rmst_model rmst_i (.*);

    load_tile_top dut_i (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task draw_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task log_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("** Error: load %0d %s = 0x%08h, expected 0x%08h", cur_row, name, got, exp);
        err_cnt++;
    endtask

    task raise_fault(input string what);
        $display("Error: load %0d: %s", cur_row, what);
        err_cnt++;
    endtask

    // sink: hands back one credit per word, at once or when the LFSR allows
    always @(negedge clk) begin : sink
        logic b0, b1;
        if (rst) begin
            out_credit = 1'b0;
        end else begin
            b0 = 1'b1;
            b1 = 1'b1;
            if (sink_gated && owed != 0) begin
                draw_bit(b0);
                draw_bit(b1);
            end
            if (owed != 0 && b0 && b1) begin
                out_credit = 1'b1;
                owed       = owed - 1;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    always @(posedge clk) begin : monitor
        word_t exp_word;
        if (!rst) begin
            if (out_valid) begin
                valid_cnt++;
                owed++;
                if (valid_cnt > credit_cnt + SINK_CREDITS) begin
                    raise_fault("sink received a word without holding a credit");
                end
                exp_word = (row_base + addr_t'(4 * word_idx)) ^ MEM_KEY;
                if (!row_active) begin
                    raise_fault("word arrived with no load running");
                end else if (word_idx >= row_len) begin
                    raise_fault("more words than the load length");
                end else begin
                    if (out_data !== exp_word) begin
                        log_mismatch("out_data", out_data, exp_word);
                    end
                    if (out_last !== (word_idx == row_len - 1)) begin
                        log_mismatch("out_last", out_last, word_idx == row_len - 1);
                    end
                end
                word_idx++;
            end
            if (out_credit) begin
                credit_cnt++;
            end
            if (load_done) begin
                done_cnt++;
                if (!(out_valid && out_last)) begin
                    raise_fault("load_done pulsed without the last word");
                end
            end
            if (rmst_user_read_buffer && !rmst_user_data_available) begin
                raise_fault("beat popped while the read master had none");
            end
            if (rmst_go) begin
                if (rmst_read_length > len_t'(32)) begin
                    log_mismatch("rmst_read_length (max)", rmst_read_length, 32);
                end
                if (rmst_read_base !== next_burst) begin
                    log_mismatch("rmst_read_base", rmst_read_base, next_burst);
                end
                next_burst  = next_burst + addr_t'(rmst_read_length);
                burst_bytes = burst_bytes + int'(rmst_read_length);
            end
        end
    end

    // cycle limit from the table lengths
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task run_load(input int r);
        int errs_before;
        errs_before = err_cnt;
        cur_row     = r;
        row_base    = LOADS[r].base;
        row_len     = int'(LOADS[r].len);
        sink_gated  = LOADS[r].gated;
        word_idx    = 0;
        done_cnt    = 0;
        next_burst  = row_base;
        burst_bytes = 0;
        row_active  = 1'b1;
        load_base   = LOADS[r].base;
        load_len    = LOADS[r].len;
        load_start  = 1'b1;
        @(negedge clk);
        load_start = 1'b0;
        if (!load_busy) begin
            raise_fault("load_busy did not rise after load_start");
        end
        while (done_cnt == 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (load_busy) begin
            raise_fault("load_busy still high after load_done");
        end
        // idle gap catches stray words before the counts are checked
        repeat (10) @(negedge clk);
        // next load starts with every sink credit handed back
        while (owed != 0) begin
            @(negedge clk);
        end
        if (word_idx != row_len) begin
            log_mismatch("word count", word_idx, row_len);
        end
        if (done_cnt != 1) begin
            log_mismatch("load_done count", done_cnt, 1);
        end
        if (burst_bytes != row_len * 4) begin
            log_mismatch("burst bytes", burst_bytes, row_len * 4);
        end
        row_active = 1'b0;
        if (err_cnt == errs_before) begin
            passed++;
            $display("load %0d base 0x%08h len %0d %s: ok", r, row_base, row_len,
                     sink_gated ? "gated" : "prompt");
        end else begin
            failed++;
            $display("load %0d base 0x%08h len %0d %s: %0d errors", r, row_base, row_len,
                     sink_gated ? "gated" : "prompt", err_cnt - errs_before);
        end
    endtask

    initial begin
        load_start  = 1'b0;
        load_base   = '0;
        load_len    = '0;
        out_credit  = 1'b0;
        row_active  = 1'b0;
        sink_gated  = 1'b0;
        row_base    = '0;
        row_len     = 0;
        next_burst  = '0;
        lfsr        = 32'hc6acd34b;
        err_cnt     = 0;
        passed      = 0;
        failed      = 0;
        cur_row     = 0;
        word_idx    = 0;
        done_cnt    = 0;
        burst_bytes = 0;
        owed        = 0;
        valid_cnt   = 0;
        credit_cnt  = 0;
        cycles      = 0;
        limit       = 0;
        for (int r = 0; r < NROWS; r++) begin
            limit = limit + int'(LOADS[r].len) * 8 + 200;
        end

        @(negedge rst);
        repeat (2) @(negedge clk);
        for (int r = 0; r < NROWS; r++) begin
            run_load(r);
        end

        if (dut_i.issuer_i.props_i.fails != 0) begin
            $display("Error: %0d assertion failures in the burst issuer",
                     dut_i.issuer_i.props_i.fails);
            err_cnt = err_cnt + int'(dut_i.issuer_i.props_i.fails);
        end
        $display("loads run %0d, passed %0d, failed %0d, errors %0d",
                 NROWS, passed, failed, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
